//--- filelist.f
source/dbgbus_pkg.sv
source/wb_scratch_ram.sv
source/wb_led_regs.sv
source/wb_addr_decode.sv
source/dbgbus_wb_master.sv
source/dbgbus_top.sv
tb/dbgbus_tb.sv

//--- tb/dbgbus_tb.sv
`timescale 1ns/1ns

module dbgbus_tb;

    localparam int RSP_TIMEOUT = 40;    // cycles allowed per response

    logic        i_clk = 1'b0;
    logic        i_reset;
    logic        i_cmd_stb;
    logic [33:0] i_cmd_word;
    logic        i_button;
    logic        o_cmd_busy;
    logic        o_rsp_stb;
    logic [33:0] o_rsp_word;
    logic [7:0]  o_leds;

    int          errors;
    int          timeouts;
    logic [31:0] rng_state;
    logic [31:0] ram_model [0:255];     // expected scratch ram contents

    dbgbus_top i_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_cmd_stb  (i_cmd_stb),
        .i_cmd_word (i_cmd_word),
        .o_cmd_busy (o_cmd_busy),
        .o_rsp_stb  (o_rsp_stb),
        .o_rsp_word (o_rsp_word),
        .i_button   (i_button),
        .o_leds     (o_leds)
    );

    // 20 ns clock
    initial begin
        forever #10 i_clk = ~i_clk;
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [33:0] addr_cmd(input logic rel, input logic inc,
                                             input logic [29:0] addr);
        dbgbus_pkg::cmd_word_u w;
        w.a.cls  = dbgbus_pkg::CMD_SUB_ADDR;
        w.a.rel  = rel;
        w.a.inc  = inc;
        w.a.addr = addr;
        return w;
    endfunction

    function automatic logic [33:0] bus_cmd(input logic [1:0] cls, input logic [31:0] data);
        dbgbus_pkg::cmd_word_u w;
        w.d.cls  = cls;
        w.d.data = data;    // don't care on reads
        return w;
    endfunction

    function automatic logic [33:0] bus_err_rsp();
        return {dbgbus_pkg::RSP_SUB_SPECIAL, dbgbus_pkg::RSP_SPECIAL_BUS_ERROR, 29'd0};
    endfunction

    task automatic check_word(input string name, input logic [33:0] exp,
                              input logic [33:0] act);
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_int(input string name, input int exp, input int act);
        assert (act == exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // one-cycle command strobe then poll for the response
    task automatic send_and_wait(input string name, input logic [33:0] cmd,
                                 output logic [33:0] rsp, output int cycles,
                                 output bit got, output logic busy_before);
        @(negedge i_clk);
        i_cmd_stb  = 1'b1;
        i_cmd_word = cmd;
        cycles      = 0;
        got         = 1'b0;
        rsp         = 'x;
        busy_before = 1'b0;
        while (!got && cycles < RSP_TIMEOUT) begin
            @(negedge i_clk);
            i_cmd_stb = 1'b0;
            cycles++;
            if (o_rsp_stb) begin
                got = 1'b1;
                rsp = o_rsp_word;
            end else begin
                busy_before = o_cmd_busy;   // last look before the response
            end
        end
        if (!got) begin
            timeouts++;
            $display("timeout in %s: no response within %0d cycles", name, RSP_TIMEOUT);
        end
    endtask

    // address command with its echo checked against the expected address
    task automatic set_addr(input string name, input logic rel, input logic inc,
                            input logic [29:0] payload, input logic [29:0] exp_addr);
        logic [33:0] rsp;
        int          cycles;
        bit          got;
        logic        busy;
        send_and_wait(name, addr_cmd(rel, inc, payload), rsp, cycles, got, busy);
        if (got) begin
            check_word(name, {dbgbus_pkg::RSP_SUB_ADDR, 1'b0, inc, exp_addr}, rsp);
            check_int({name, " latency"}, 2, cycles);
            check_int({name, " busy"}, 0, busy);    // no bus cycle for an address
        end
    endtask

    task automatic bus_access(input string name, input logic [33:0] cmd,
                              input logic [33:0] exp_rsp);
        logic [33:0] rsp;
        int          cycles;
        bit          got;
        logic        busy;
        send_and_wait(name, cmd, rsp, cycles, got, busy);
        if (got) begin
            check_word(name, exp_rsp, rsp);
            check_int({name, " busy held"}, 1, busy);     // high while the cycle runs
            check_int({name, " busy"}, 0, o_cmd_busy);  // drops with the response
        end
    endtask

    task automatic write_word(input string name, input logic [31:0] data);
        bus_access(name, bus_cmd(dbgbus_pkg::CMD_SUB_WR, data),
                   {dbgbus_pkg::RSP_SUB_ACK, 32'd0});
    endtask

    task automatic read_word(input string name, input logic [31:0] exp);
        bus_access(name, bus_cmd(dbgbus_pkg::CMD_SUB_RD, 32'd0),
                   {dbgbus_pkg::RSP_SUB_DATA, exp});
    endtask

    task automatic reset_announce_test();
        int cycles;
        bit got;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < RSP_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
            got = o_rsp_stb;
        end
        if (!got) begin
            timeouts++;
            $display("timeout in reset_announce: no response after reset");
        end else begin
            check_word("reset_announce", {dbgbus_pkg::RSP_SUB_SPECIAL,
                       dbgbus_pkg::RSP_SPECIAL_RESET, 29'd0}, o_rsp_word);
            check_int("reset_announce latency", 1, cycles);
            check_int("reset_announce leds", 0, o_leds);
            @(negedge i_clk);
            check_int("reset_announce width", 0, o_rsp_stb);   // single cycle only
        end
    endtask

    task automatic address_test();
        set_addr("addr_absolute", 1'b0, 1'b0, 30'h010, 30'h010);
        set_addr("addr_relative", 1'b1, 1'b0, 30'h025, 30'h035);
        set_addr("addr_relative_neg", 1'b1, 1'b1, 30'h3FFF_FFFB, 30'h030); // minus 5 with wrap
    endtask

    task automatic ram_test();
        logic [7:0]  addrs [0:7];
        logic [31:0] data;
        int          i;
        for (i = 0; i < 8; i++) begin
            data     = next_random();
            addrs[i] = data[7:0];
            data     = next_random();
            set_addr("ram_write_addr", 1'b0, 1'b0, {22'd0, addrs[i]}, {22'd0, addrs[i]});
            write_word("ram_write", data);
            ram_model[addrs[i]] = data;
        end
        for (i = 0; i < 8; i++) begin
            set_addr("ram_read_addr", 1'b0, 1'b0, {22'd0, addrs[i]}, {22'd0, addrs[i]});
            read_word("ram_read", ram_model[addrs[i]]);
        end
    endtask

    task automatic auto_inc_test();
        logic [31:0] data;
        int          i;
        set_addr("inc_start", 1'b0, 1'b1, 30'h040, 30'h040);
        for (i = 0; i < 4; i++) begin
            data = next_random();
            write_word("inc_write", data);
            ram_model[8'h40 + i] = data;
        end
        set_addr("inc_rewind", 1'b0, 1'b1, 30'h040, 30'h040);
        for (i = 0; i < 4; i++)
            read_word("inc_read", ram_model[8'h40 + i]);
        set_addr("inc_final", 1'b1, 1'b1, 30'd0, 30'h044);    // start plus 4 reads
    endtask

    task automatic reg_test();
        logic [31:0] data;
        data = next_random();
        set_addr("reg_led_addr", 1'b0, 1'b0, dbgbus_pkg::REG_BASE, dbgbus_pkg::REG_BASE);
        write_word("reg_led_write", data);
        check_word("reg_led_pins", {26'd0, data[7:0]}, {26'd0, o_leds});
        read_word("reg_led_read", {24'd0, data[7:0]});
        i_button = 1'b1;
        repeat (2) @(negedge i_clk);    // through the two-flop sync
        set_addr("reg_btn_addr", 1'b0, 1'b0, dbgbus_pkg::REG_BASE + 30'd1,
                 dbgbus_pkg::REG_BASE + 30'd1);
        read_word("reg_btn_high", 32'd1);
        // low byte differs from the leds and bit 0 differs from the button
        write_word("reg_status_write", {24'd0, ~data[7:1], 1'b0});
        read_word("reg_status_kept", 32'd1);
        check_word("reg_led_untouched", {26'd0, data[7:0]}, {26'd0, o_leds});
        i_button = 1'b0;
        repeat (2) @(negedge i_clk);
        read_word("reg_btn_low", 32'd0);
    endtask

    task automatic bus_error_test();
        set_addr("err_addr", 1'b0, 1'b0, 30'h200, 30'h200);
        bus_access("err_read", bus_cmd(dbgbus_pkg::CMD_SUB_RD, 32'd0), bus_err_rsp());
        bus_access("err_write", bus_cmd(dbgbus_pkg::CMD_SUB_WR, 32'h1234_5678),
                   bus_err_rsp());
        // first word past the register window
        set_addr("err_past_regs_addr", 1'b0, 1'b0, dbgbus_pkg::REG_BASE + 30'd2,
                 dbgbus_pkg::REG_BASE + 30'd2);
        bus_access("err_past_regs", bus_cmd(dbgbus_pkg::CMD_SUB_RD, 32'd0), bus_err_rsp());
        set_addr("err_recover_addr", 1'b0, 1'b0, 30'h040, 30'h040);
        read_word("err_recover", ram_model[8'h40]);
    endtask

    initial begin
        errors     = 0;
        timeouts   = 0;
        rng_state  = 32'd72759;
        i_reset    = 1'b1;
        i_cmd_stb  = 1'b0;
        i_cmd_word = '0;
        i_button   = 1'b0;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;

        reset_announce_test();
        address_test();
        ram_test();
        auto_inc_test();
        reg_test();
        bus_error_test();

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- source/dbgbus_top.sv
`timescale 1ns/1ns

module dbgbus_top (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_cmd_stb,
    input  logic [33:0] i_cmd_word,
    output logic        o_cmd_busy,
    output logic        o_rsp_stb,
    output logic [33:0] o_rsp_word,
    input  logic        i_button,
    output logic [7:0]  o_leds
);

    // master side of the bus
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [29:0] wb_addr;
    logic [31:0] wb_mdata;  // master to slaves
    logic        wb_stall;
    logic        wb_ack;
    logic        wb_err;
    logic [31:0] wb_sdata;  // slaves back to master

    // per-slave returns
    logic        ram_stb;
    logic        ram_stall;
    logic        ram_ack;
    logic [31:0] ram_data;
    logic        reg_stb;
    logic        reg_ack;
    logic [31:0] reg_data;

    dbgbus_wb_master u_master (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_cmd_stb  (i_cmd_stb),
        .i_cmd_word (i_cmd_word),
        .o_cmd_busy (o_cmd_busy),
        .o_rsp_stb  (o_rsp_stb),
        .o_rsp_word (o_rsp_word),
        .o_wb_cyc   (wb_cyc),
        .o_wb_stb   (wb_stb),
        .o_wb_we    (wb_we),
        .o_wb_addr  (wb_addr),
        .o_wb_data  (wb_mdata),
        .i_wb_stall (wb_stall),
        .i_wb_ack   (wb_ack),
        .i_wb_err   (wb_err),
        .i_wb_data  (wb_sdata)
    );

    wb_addr_decode u_decode (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_addr   (wb_addr),
        .o_wb_stall  (wb_stall),
        .o_wb_ack    (wb_ack),
        .o_wb_err    (wb_err),
        .o_wb_data   (wb_sdata),
        .o_ram_stb   (ram_stb),
        .i_ram_stall (ram_stall),
        .i_ram_ack   (ram_ack),
        .i_ram_data  (ram_data),
        .o_reg_stb   (reg_stb),
        .i_reg_ack   (reg_ack),
        .i_reg_data  (reg_data)
    );

    // ram window starts at word 0, low bits are the index
    wb_scratch_ram u_ram (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (ram_stb),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr[dbgbus_pkg::RAM_AW-1:0]),
        .i_wb_data  (wb_mdata),
        .o_wb_stall (ram_stall),
        .o_wb_ack   (ram_ack),
        .o_wb_data  (ram_data)
    );

    wb_led_regs u_regs (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wb_cyc  (wb_cyc),
        .i_wb_stb  (reg_stb),
        .i_wb_we   (wb_we),
        .i_wb_addr (wb_addr[0]),    // two registers, one index bit
        .i_wb_data (wb_mdata),
        .o_wb_ack  (reg_ack),
        .o_wb_data (reg_data),
        .i_button  (i_button),
        .o_leds    (o_leds)
    );

endmodule

//--- source/dbgbus_wb_master.sv
`timescale 1ns/1ns

module dbgbus_wb_master (
    input  logic        i_clk,
    input  logic        i_reset,
    // command stream in
    input  logic        i_cmd_stb,
    input  logic [33:0] i_cmd_word,
    output logic        o_cmd_busy,
    // response stream out, no back-pressure
    output logic        o_rsp_stb,
    output logic [33:0] o_rsp_word,
    // wishbone master side
    output logic        o_wb_cyc,
    output logic        o_wb_stb,
    output logic        o_wb_we,
    output logic [29:0] o_wb_addr,
    output logic [31:0] o_wb_data,
    input  logic        i_wb_stall,
    input  logic        i_wb_ack,
    input  logic        i_wb_err,
    input  logic [31:0] i_wb_data
);

    dbgbus_pkg::cmd_word_u cmd; // incoming word, both views

    logic is_addr;      // address command
    logic is_bus;       // read or write command
    logic take_addr;    // address command accepted this cycle
    logic take_bus;     // bus command accepted this cycle
    logic bus_done;     // ack or err ends the cycle
    logic inc_flag;     // auto-increment after each access
    logic new_addr;     // echo pending next cycle
    logic reset_ann;    // reset announcement pending

    assign cmd = i_cmd_word;

    // class decode, special falls through both and is dropped
    assign is_addr = (cmd.a.cls == dbgbus_pkg::CMD_SUB_ADDR);
    assign is_bus  = (cmd.d.cls == dbgbus_pkg::CMD_SUB_RD)
                  || (cmd.d.cls == dbgbus_pkg::CMD_SUB_WR);

    // commands only land while the bus is idle
    assign take_addr = i_cmd_stb && !o_wb_cyc && is_addr;
    assign take_bus  = i_cmd_stb && !o_wb_cyc && is_bus;

    assign bus_done = o_wb_cyc && (i_wb_ack || i_wb_err);

    // one transaction at a time, so busy is just cyc
    assign o_cmd_busy = o_wb_cyc;

    // bus sequence, state lives in cyc/stb
    //   idle    : !cyc
    //   request : cyc && stb, waiting on stall
    //   wait    : cyc && !stb, waiting on ack or err
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
        end else if (o_wb_cyc) begin
            if (o_wb_stb && !i_wb_stall)
                o_wb_stb <= 1'b0;   // request accepted
            if (i_wb_ack || i_wb_err) begin
                o_wb_cyc <= 1'b0;   // cycle over either way
                o_wb_stb <= 1'b0;
            end
        end else if (take_bus) begin
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
        end
    end

    // direction and write data, held for the whole cycle
    always_ff @(posedge i_clk) begin
        if (take_bus) begin
            o_wb_we   <= (cmd.d.cls == dbgbus_pkg::CMD_SUB_WR);
            o_wb_data <= cmd.d.data;
        end
    end

    // current address and increment flag
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_addr <= '0;
            inc_flag  <= 1'b0;
            new_addr  <= 1'b0;
        end else begin
            new_addr <= 1'b0;
            if (take_addr) begin
                if (cmd.a.rel)
                    o_wb_addr <= o_wb_addr + cmd.a.addr; // relative, wraps
                else
                    o_wb_addr <= cmd.a.addr;
                inc_flag <= cmd.a.inc;
                new_addr <= 1'b1;                         // echo next cycle
            end else if (bus_done && inc_flag) begin
                o_wb_addr <= o_wb_addr + 30'd1;           // err steps too
            end
        end
    end

    // response strobe, one cycle wide
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp_stb <= 1'b0;
            reset_ann <= 1'b1;      // announce once reset lets go
        end else begin
            o_rsp_stb <= reset_ann || bus_done || new_addr;
            reset_ann <= 1'b0;
        end
    end

    // response payload
    // announcement first, it can never overlap a bus or address response
    always_ff @(posedge i_clk) begin
        if (reset_ann) begin
            o_rsp_word <= {dbgbus_pkg::RSP_SUB_SPECIAL,
                           dbgbus_pkg::RSP_SPECIAL_RESET, 29'd0};
        end else if (o_wb_cyc && i_wb_err) begin
            o_rsp_word <= {dbgbus_pkg::RSP_SUB_SPECIAL,
                           dbgbus_pkg::RSP_SPECIAL_BUS_ERROR, 29'd0};
        end else if (o_wb_cyc && i_wb_ack) begin
            if (o_wb_we)
                o_rsp_word <= {dbgbus_pkg::RSP_SUB_ACK, 32'd0};
            else
                o_rsp_word <= {dbgbus_pkg::RSP_SUB_DATA, i_wb_data};
        end else if (new_addr) begin
            // echo never carries the relative flag
            o_rsp_word <= {dbgbus_pkg::RSP_SUB_ADDR, 1'b0, inc_flag, o_wb_addr};
        end
    end

    // host side must respect busy
    a_no_cmd_while_busy : assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_cmd_stb |-> !o_cmd_busy
    ) else $error("command strobe while master busy");

    // a request only ever sits inside an open cycle
    a_stb_in_cyc : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wb_stb |-> o_wb_cyc
    ) else $error("wishbone stb without cyc");

endmodule

//--- source/wb_addr_decode.sv
`timescale 1ns/1ns

module wb_addr_decode (
    input  logic        i_clk,
    input  logic        i_reset,
    // from the master
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic [29:0] i_wb_addr,
    output logic        o_wb_stall,
    output logic        o_wb_ack,
    output logic        o_wb_err,
    output logic [31:0] o_wb_data,
    // scratch ram
    output logic        o_ram_stb,
    input  logic        i_ram_stall,
    input  logic        i_ram_ack,
    input  logic [31:0] i_ram_data,
    // led / button registers
    output logic        o_reg_stb,
    input  logic        i_reg_ack,
    input  logic [31:0] i_reg_data
);

    logic ram_sel;      // address inside ram window
    logic reg_sel;      // address inside register window
    logic err_q;        // unmapped request, answered one cycle later

    // window compares against the package map
    assign ram_sel = (i_wb_addr >= dbgbus_pkg::RAM_BASE)
                  && (i_wb_addr <  dbgbus_pkg::RAM_BASE + 2**dbgbus_pkg::RAM_AW);
    assign reg_sel = (i_wb_addr >= dbgbus_pkg::REG_BASE)
                  && (i_wb_addr <  dbgbus_pkg::REG_BASE + dbgbus_pkg::REG_COUNT);

    // stb to at most one slave
    assign o_ram_stb = i_wb_cyc && i_wb_stb && ram_sel;
    assign o_reg_stb = i_wb_cyc && i_wb_stb && reg_sel;

    assign o_wb_stall = ram_sel ? i_ram_stall : 1'b0; // regs and the void never stall
    assign o_wb_ack   = i_ram_ack || i_reg_ack;
    assign o_wb_data  = reg_sel ? i_reg_data : i_ram_data; // addr held until ack

    // unmapped: accept at once, err next cycle
    always_ff @(posedge i_clk) begin
        if (i_reset)
            err_q <= 1'b0;
        else
            err_q <= i_wb_cyc && i_wb_stb && !ram_sel && !reg_sel;
    end

    assign o_wb_err = err_q;

    a_one_slave : assert property (
        @(posedge i_clk) disable iff (i_reset)
        !(o_ram_stb && o_reg_stb)
    ) else $error("decoder strobed both slaves");

endmodule

//--- source/wb_led_regs.sv
`timescale 1ns/1ns

module wb_led_regs (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic        i_wb_addr,  // 0 = leds, 1 = button status
    input  logic [31:0] i_wb_data,
    output logic        o_wb_ack,
    output logic [31:0] o_wb_data,
    input  logic        i_button,   // async, from the pin
    output logic [7:0]  o_leds
);

    logic accept;       // no stall, so every stb is taken
    logic btn_meta;     // first sync flop
    logic btn_sync;     // safe to read

    assign accept = i_wb_cyc && i_wb_stb;

    // two-flop synchronizer
    always_ff @(posedge i_clk) begin
        btn_meta <= i_button;
        btn_sync <= btn_meta;
    end

    // led register and ack
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_leds   <= 8'd0;
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= accept;
            if (accept && i_wb_we && !i_wb_addr)
                o_leds <= i_wb_data[7:0];   // status writes just ack
        end
    end

    // read data, zero-extended
    always_ff @(posedge i_clk) begin
        if (accept)
            o_wb_data <= i_wb_addr ? {31'd0, btn_sync} : {24'd0, o_leds};
    end

endmodule

//--- source/wb_scratch_ram.sv
`timescale 1ns/1ns

module wb_scratch_ram (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic [7:0]  i_wb_addr,  // word index
    input  logic [31:0] i_wb_data,
    output logic        o_wb_stall,
    output logic        o_wb_ack,
    output logic [31:0] o_wb_data
);

    logic [31:0] mem [0:2**dbgbus_pkg::RAM_AW-1];

    logic waited;   // first stall cycle of this request already spent
    logic accept;   // request taken this cycle

    // stall the first cycle of each request
    assign o_wb_stall = i_wb_stb && !waited;
    assign accept     = i_wb_cyc && i_wb_stb && waited;

    // wait-state flag
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            waited <= 1'b0;
        end else if (!i_wb_cyc) begin
            waited <= 1'b0;     // cycle dropped, start over
        end else if (accept) begin
            waited <= 1'b0;     // ready for the next request
        end else if (i_wb_stb) begin
            waited <= 1'b1;     // one stall spent
        end
    end

    // ack one cycle after acceptance
    always_ff @(posedge i_clk) begin
        if (i_reset)
            o_wb_ack <= 1'b0;
        else
            o_wb_ack <= accept;
    end

    // storage, write data latched at acceptance
    always_ff @(posedge i_clk) begin
        if (accept && i_wb_we)
            mem[i_wb_addr] <= i_wb_data;
    end

    // registered read, lines up with ack
    always_ff @(posedge i_clk) begin
        if (accept)
            o_wb_data <= mem[i_wb_addr];
    end

    // ack must not outlive the cycle that asked for it
    a_ack_in_cyc : assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wb_ack |-> i_wb_cyc
    ) else $error("ram ack outside of a bus cycle");

endmodule

//--- source/dbgbus_pkg.sv
package dbgbus_pkg;

    // command class, top two bits of every command word
    localparam logic [1:0] CMD_SUB_RD      = 2'd0; // single read at current address
    localparam logic [1:0] CMD_SUB_WR      = 2'd1; // single write, payload is the data
    localparam logic [1:0] CMD_SUB_ADDR    = 2'd2; // set address, absolute or relative
    localparam logic [1:0] CMD_SUB_SPECIAL = 2'd3; // reserved, master drops it

    // response class, top two bits of every response word
    localparam logic [1:0] RSP_SUB_DATA    = 2'd0; // read data follows
    localparam logic [1:0] RSP_SUB_ACK     = 2'd1; // write done, zero payload
    localparam logic [1:0] RSP_SUB_ADDR    = 2'd2; // address echo
    localparam logic [1:0] RSP_SUB_SPECIAL = 2'd3; // code in bits 31:29

    // special response codes, rest of the word is zero
    localparam logic [2:0] RSP_SPECIAL_RESET     = 3'd0;
    localparam logic [2:0] RSP_SPECIAL_BUS_ERROR = 3'd1;

    // wishbone word address width
    localparam int WB_ADDR_W = 30;

    // address map, all in word addresses
    localparam int                   RAM_AW    = 8;       // 256 words of scratch
    localparam logic [WB_ADDR_W-1:0] RAM_BASE  = 30'h000;
    localparam logic [WB_ADDR_W-1:0] REG_BASE  = 30'h100;
    localparam int                   REG_COUNT = 2;       // led reg, button status
    // anything outside the two windows gets a bus error

    // one command word, two readings of the low 32 bits
    typedef union packed {
        // read / write view
        struct packed {
            logic [1:0]  cls;  // command class
            logic [31:0] data; // write data, ignored on reads
        } d;
        // address view
        struct packed {
            logic [1:0]           cls;  // command class
            logic                 rel;  // add to current address
            logic                 inc;  // bump address after each access
            logic [WB_ADDR_W-1:0] addr; // word address or offset
        } a;
    } cmd_word_u;

    // a 34-bit word in, a 34-bit word out
    // every bus access is a full word, no byte selects
    // only one bus transaction is ever in flight

endpackage
